// File: Makefile
TOP := keccak_ctrl_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f keccak_ctrl.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: keccak_ctrl.f
rtl/keccak_pkg.sv
rtl/wb_reg_slave.sv
rtl/msg_fifo.sv
rtl/keccak_sponge_core.sv
rtl/keccak_ctrl.sv
testbench/keccak_ctrl_assertions.sv
testbench/keccak_ctrl_tb.sv

// File: rtl/keccak_ctrl.sv
`timescale 1ns/10ps

module keccak_ctrl #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset_n,
  input  keccak_pkg::wb_req_t bus_req_i,
  output keccak_pkg::wb_rsp_t bus_rsp_o,
  output logic                busy_o
);

  import keccak_pkg::*;

  logic           push;
  msg_word_t      push_word;
  logic           pop;
  msg_word_t      pop_word;
  logic           fifo_full;
  logic           fifo_empty;
  logic           init;
  sponge_status_t status;

  // Bus side, producer of message words
  wb_reg_slave wb_reg_slave_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .fifo_full_i  (fifo_full),
    .fifo_empty_i (fifo_empty),
    .push_o       (push),
    .push_word_o  (push_word),
    .init_o       (init),
    .status_i     (status)
  );

  msg_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) msg_fifo_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .push_i      (push),
    .push_word_i (push_word),
    .pop_i       (pop),
    .pop_word_o  (pop_word),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty)
  );

  keccak_sponge_core keccak_sponge_core_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .word_i   (pop_word),
    .empty_i  (fifo_empty),
    .pop_o    (pop),
    .init_i   (init),
    .status_o (status)
  );

  assign busy_o = status.busy | ~fifo_empty;  // Queued words count as busy

endmodule

// File: rtl/keccak_pkg.sv
package keccak_pkg;

  // Wishbone classic request, driven by the master
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;  // Byte address
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef logic [31:0] msg_word_t;  // Byte 0 in bits 7:0

  typedef struct packed {
    logic        busy;
    logic [63:0] digest;
  } sponge_status_t;

  // 25 lanes of 8 bits, lane index x + 5*y
  typedef logic [24:0][7:0] keccak_state_t;

  // Register byte offsets
  localparam logic [7:0] ADDR_CTRL      = 8'h00;
  localparam logic [7:0] ADDR_STATUS    = 8'h04;
  localparam logic [7:0] ADDR_MSG       = 8'h08;
  localparam logic [7:0] ADDR_DIGEST_LO = 8'h0C;
  localparam logic [7:0] ADDR_DIGEST_HI = 8'h10;

  localparam int NUM_ROUNDS = 18;
  localparam int RATE_WORDS = 2;

  // Low byte of the Keccak round constants, entry 17 first
  localparam logic [NUM_ROUNDS-1:0][7:0] ROUND_CONST = {
    8'h80, 8'h02, 8'h03, 8'h89, 8'h8B, 8'h8B, 8'h0A, 8'h09, 8'h88,
    8'h8A, 8'h09, 8'h81, 8'h01, 8'h8B, 8'h00, 8'h8A, 8'h82, 8'h01
  };

  // Rho offsets mod 8, lane 24 first
  localparam logic [24:0][2:0] RHO_OFFSETS = {
    3'd6, 3'd0, 3'd5, 3'd2, 3'd2,
    3'd0, 3'd5, 3'd7, 3'd5, 3'd1,
    3'd7, 3'd1, 3'd3, 3'd2, 3'd3,
    3'd4, 3'd7, 3'd6, 3'd4, 3'd4,
    3'd3, 3'd4, 3'd6, 3'd1, 3'd0
  };

endpackage

// File: rtl/keccak_sponge_core.sv
`timescale 1ns/10ps

module keccak_sponge_core (
  input  logic                       clk,
  input  logic                       reset_n,
  input  keccak_pkg::msg_word_t      word_i,
  input  logic                       empty_i,
  output logic                       pop_o,
  input  logic                       init_i,
  output keccak_pkg::sponge_status_t status_o
);

  import keccak_pkg::*;

  localparam int RATE_BYTES = RATE_WORDS * 4;

  typedef enum logic [1:0] {
    IDLE,
    ABSORB1,
    PERMUTE
  } fsm_e;

  fsm_e          fsm_q;
  logic [4:0]    round_q;
  keccak_state_t st_q;
  logic          last_round;

  // ====================================================================
  // Keccak-f[200] round
  // ====================================================================

  function automatic logic [7:0] rotl8(logic [7:0] v, logic [2:0] n);
    return (v << n) | (v >> (8 - int'(n)));  // Shift by 8 gives zero for n = 0
  endfunction

  function automatic keccak_state_t keccak_round(keccak_state_t a, logic [4:0] rnd);
    logic [4:0][7:0] c;
    logic [4:0][7:0] d;
    keccak_state_t   b;
    keccak_state_t   r;
    // Theta
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];  // Column parity
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x + 4) % 5] ^ rotl8(c[(x + 1) % 5], 3'd1);
    end
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        a[x + 5 * y] = a[x + 5 * y] ^ d[x];
      end
    end
    // Rho and pi
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[y + 5 * ((2 * x + 3 * y) % 5)] = rotl8(a[x + 5 * y], RHO_OFFSETS[x + 5 * y]);
      end
    end
    // Chi
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        r[x + 5 * y] = b[x + 5 * y] ^
                       (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
      end
    end
    r[0] = r[0] ^ ROUND_CONST[rnd];  // Iota
    return r;
  endfunction

  // ====================================================================
  // Absorb and permute control
  // ====================================================================

  assign last_round = (round_q == 5'(NUM_ROUNDS - 1));

  // Init wins over a pop in the same idle cycle
  always_comb begin
    case (fsm_q)
      IDLE:    pop_o = ~init_i & ~empty_i;
      ABSORB1: pop_o = ~empty_i;
      default: pop_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fsm_q   <= IDLE;
      round_q <= '0;
      st_q    <= '0;
    end else begin
      case (fsm_q)
        IDLE: begin
          if (init_i) begin
            st_q <= '0;
          end else if (!empty_i) begin
            st_q[3:0] <= st_q[3:0] ^ word_i;  // Word 0 into bytes 0..3
            fsm_q     <= ABSORB1;
          end
        end
        ABSORB1: begin
          if (!empty_i) begin
            st_q[7:4] <= st_q[7:4] ^ word_i;  // Word 1 into bytes 4..7
            round_q   <= '0;
            fsm_q     <= PERMUTE;
          end
        end
        PERMUTE: begin
          st_q    <= keccak_round(st_q, round_q);
          round_q <= round_q + 1'b1;
          if (last_round) begin
            fsm_q <= IDLE;
          end
        end
        default: fsm_q <= IDLE;
      endcase
    end
  end

  // Digest is the live rate part, stable while idle
  assign status_o.busy   = (fsm_q != IDLE);
  assign status_o.digest = st_q[RATE_BYTES-1:0];

endmodule

// File: rtl/msg_fifo.sv
`timescale 1ns/10ps

module msg_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  push_i,
  input  keccak_pkg::msg_word_t push_word_i,
  input  logic                  pop_i,
  output keccak_pkg::msg_word_t pop_word_o,
  output logic                  full_o,
  output logic                  empty_o
);

  import keccak_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  msg_word_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_word_i;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count unchanged on a push and pop together
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign pop_word_o = mem[rd_ptr_q];  // Head word, valid while not empty
  assign full_o     = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o    = (count_q == '0);

endmodule

// File: rtl/wb_reg_slave.sv
`timescale 1ns/10ps

module wb_reg_slave (
  input  logic                       clk,
  input  logic                       reset_n,
  input  keccak_pkg::wb_req_t        bus_req_i,
  output keccak_pkg::wb_rsp_t        bus_rsp_o,
  input  logic                       fifo_full_i,
  input  logic                       fifo_empty_i,
  output logic                       push_o,
  output keccak_pkg::msg_word_t      push_word_o,
  output logic                       init_o,
  input  keccak_pkg::sponge_status_t status_i
);

  import keccak_pkg::*;

  logic        ack_q;
  logic        ack_d;
  logic [31:0] rdata_q;
  logic [31:0] rd_mux;
  logic        req_valid;
  logic        msg_wr;
  logic        msg_stall;
  logic        busy_bit;

  // ====================================================================
  // Request decode
  // ====================================================================

  // A request is new until its ack has been returned
  assign req_valid = bus_req_i.cyc & bus_req_i.stb & ~ack_q;

  assign msg_wr    = req_valid & bus_req_i.we & (bus_req_i.adr == ADDR_MSG);
  assign msg_stall = msg_wr & fifo_full_i;  // Ack held back while the FIFO is full

  assign ack_d = req_valid & ~msg_stall;

  // Partial MSG writes are acked but never reach the FIFO
  assign push_o      = msg_wr & ~fifo_full_i & (bus_req_i.sel == 4'hF);
  assign push_word_o = bus_req_i.dat;

  // One-cycle pulse since the request is no longer new in the ack cycle
  assign init_o = req_valid & bus_req_i.we & (bus_req_i.adr == ADDR_CTRL) &
                  bus_req_i.sel[0] & bus_req_i.dat[0];

  // Covers words still queued as well as the block in flight
  assign busy_bit = status_i.busy | ~fifo_empty_i;

  // ====================================================================
  // Read data
  // ====================================================================

  always_comb begin
    case (bus_req_i.adr)
      ADDR_STATUS:    rd_mux = {29'b0, fifo_empty_i, fifo_full_i, busy_bit};
      ADDR_DIGEST_LO: rd_mux = status_i.digest[31:0];
      ADDR_DIGEST_HI: rd_mux = status_i.digest[63:32];
      default:        rd_mux = 32'b0;  // CTRL, MSG and unmapped
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  // Data valid alongside ack
  always_ff @(posedge clk) begin
    if (ack_d) begin
      rdata_q <= bus_req_i.we ? 32'b0 : rd_mux;
    end
  end

  assign bus_rsp_o.ack = ack_q;
  assign bus_rsp_o.dat = rdata_q;

endmodule

// File: testbench/keccak_ctrl_assertions.sv
`timescale 1ns/10ps

module keccak_ctrl_assertions (
  input logic                clk,
  input logic                reset_n,
  input keccak_pkg::wb_req_t bus_req_i,
  input keccak_pkg::wb_rsp_t bus_rsp_i,
  input logic                busy_i
);

  import keccak_pkg::*;

  int   fail_count = 0;  // Read by the testbench at the end
  logic msg_seen_q;

  // First MSG request seen by the slave
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      msg_seen_q <= 1'b0;
    end else if (bus_req_i.cyc && bus_req_i.stb && bus_req_i.we &&
                 (bus_req_i.adr == ADDR_MSG)) begin
      msg_seen_q <= 1'b1;
    end
  end

  ack_with_request: assert property (@(posedge clk) disable iff (!reset_n)
    bus_rsp_i.ack |-> (bus_req_i.cyc && bus_req_i.stb))
    else begin
      fail_count = fail_count + 1;
      $error("ack high without cyc and stb");
    end

  ack_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    bus_rsp_i.ack |=> !bus_rsp_i.ack)
    else begin
      fail_count = fail_count + 1;
      $error("ack high for two cycles in a row");
    end

  idle_until_message: assert property (@(posedge clk) disable iff (!reset_n)
    !msg_seen_q |-> !busy_i)
    else begin
      fail_count = fail_count + 1;
      $error("busy_o high before any MSG write");
    end

endmodule

// File: testbench/keccak_ctrl_tb.sv
`timescale 1ns/10ps

module keccak_ctrl_tb;

  import keccak_pkg::*;

  localparam int MAX_CYCLES = 4000;  // Tests need under 1500

  logic       clk;
  logic       reset_n;
  wb_req_t    bus_req;
  wb_rsp_t    bus_rsp;
  logic       busy;
  int         cycle_count = 0;
  int         stall_cycles;
  integer     seed;
  logic [7:0] ref_state [25];  // Reference sponge state with lane index x + 5*y
  int         rho_ofs [25];
  logic [31:0] rdata;
  logic [31:0] word;

  keccak_ctrl #(
    .FIFO_DEPTH (4)
  ) keccak_ctrl_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .busy_o    (busy)
  );

  bind keccak_ctrl keccak_ctrl_assertions keccak_ctrl_assertions_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req_i (bus_req_i),
    .bus_rsp_i (bus_rsp_o),
    .busy_i    (busy_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "Stopped by timeout");
    end
  end

  // ====================================================================
  // Reference Keccak-f[200] model
  // ====================================================================

  function automatic logic [7:0] rotate_lane(input logic [7:0] v, input int n);
    return (v << n) | (v >> (8 - n));
  endfunction

  // Offsets from the triangular numbers along the (x,y) -> (y,2x+3y) walk
  function automatic void build_rho_table();
    int x;
    int y;
    int tmp;
    x = 1;
    y = 0;
    rho_ofs[0] = 0;
    for (int t = 0; t < 24; t++) begin
      rho_ofs[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 8;
      tmp = y;
      y   = (2 * x + 3 * y) % 5;
      x   = tmp;
    end
  endfunction

  // LFSR x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic rc_bit(input int t);
    logic [8:0] r;
    int         n;
    n = t % 255;
    r = 9'h001;
    for (int i = 0; i < n; i++) begin
      r    = {r[7:0], 1'b0};
      r[0] = r[0] ^ r[8];
      r[4] = r[4] ^ r[8];
      r[5] = r[5] ^ r[8];
      r[6] = r[6] ^ r[8];
    end
    return r[0];
  endfunction

  function automatic logic [7:0] iota_const(input int ir);
    logic [7:0] rc;
    rc = 8'h00;
    for (int j = 0; j <= 3; j++) begin
      rc[(1 << j) - 1] = rc_bit(j + 7 * ir);  // Bits 0, 1, 3, 7
    end
    return rc;
  endfunction

  function automatic void keccak_f200_ref();
    logic [7:0] c [5];
    logic [7:0] d [5];
    logic [7:0] b [25];
    for (int ir = 0; ir < NUM_ROUNDS; ir++) begin
      for (int x = 0; x < 5; x++) begin
        c[x] = ref_state[x] ^ ref_state[x + 5] ^ ref_state[x + 10] ^
               ref_state[x + 15] ^ ref_state[x + 20];
      end
      for (int x = 0; x < 5; x++) begin
        d[x] = c[(x + 4) % 5] ^ rotate_lane(c[(x + 1) % 5], 1);
      end
      for (int i = 0; i < 25; i++) begin
        ref_state[i] ^= d[i % 5];
      end
      for (int y = 0; y < 5; y++) begin
        for (int x = 0; x < 5; x++) begin
          b[y + 5 * ((2 * x + 3 * y) % 5)] = rotate_lane(ref_state[x + 5 * y],
                                                         rho_ofs[x + 5 * y]);
        end
      end
      for (int y = 0; y < 5; y++) begin
        for (int x = 0; x < 5; x++) begin
          ref_state[x + 5 * y] = b[x + 5 * y] ^
                                 (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
        end
      end
      ref_state[0] ^= iota_const(ir);
    end
  endfunction

  function automatic void clear_ref_state();
    for (int i = 0; i < 25; i++) begin
      ref_state[i] = 8'h00;
    end
  endfunction

  // Little-endian words into lanes 0..7 and then the permutation
  function automatic void sponge_absorb(input logic [31:0] w0, input logic [31:0] w1);
    for (int k = 0; k < 4; k++) begin
      ref_state[k]     ^= w0[8 * k +: 8];
      ref_state[k + 4] ^= w1[8 * k +: 8];
    end
    keccak_f200_ref();
  endfunction

  // ====================================================================
  // Bus tasks and checks
  // ====================================================================

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    int waits;
    @(negedge clk);
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.adr = adr;
    bus_req.dat = dat;
    bus_req.sel = sel;
    waits = 0;
    @(negedge clk);
    while (!bus_rsp.ack) begin
      waits++;  // Held back by a full FIFO
      @(negedge clk);
    end
    rdat = bus_rsp.dat;
    stall_cycles += waits;
    @(negedge clk);  // Hold through the ack edge
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    bus_req.we  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'h0, 4'hF, dat);
  endtask

  task automatic send_random_block();
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = $random(seed);
    w1 = $random(seed);
    wb_write(ADDR_MSG, w0, 4'hF);
    wb_write(ADDR_MSG, w1, 4'hF);
    sponge_absorb(w0, w1);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    wb_read(ADDR_STATUS, status);
    while (status[0]) begin
      wb_read(ADDR_STATUS, status);
    end
  endtask

  task automatic check_digest();
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(ADDR_DIGEST_LO, lo);
    wb_read(ADDR_DIGEST_HI, hi);
    check_value("digest_lo", lo, {ref_state[3], ref_state[2], ref_state[1], ref_state[0]});
    check_value("digest_hi", hi, {ref_state[7], ref_state[6], ref_state[5], ref_state[4]});
    check_value("busy_o", {31'b0, busy}, 32'h0);
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    reset_n      = 1'b0;
    bus_req      = '0;
    seed         = 32'h50f9;
    stall_cycles = 0;
    build_rho_table();
    clear_ref_state();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset values
    wb_read(ADDR_STATUS, rdata);
    check_value("status", rdata, 32'h4);  // Empty only
    wb_read(ADDR_DIGEST_LO, rdata);
    check_value("digest_lo", rdata, 32'h0);
    wb_read(ADDR_DIGEST_HI, rdata);
    check_value("digest_hi", rdata, 32'h0);
    wb_read(8'h20, rdata);
    check_value("unmapped", rdata, 32'h0);

    // Single block
    send_random_block();
    check_value("busy_o", {31'b0, busy}, 32'h1);  // Block still in the rounds
    wait_idle();
    check_digest();

    // Eight blocks back to back
    stall_cycles = 0;
    repeat (8) begin
      send_random_block();
    end
    check_value("ack_stalls_seen", {31'b0, stall_cycles != 0}, 32'h1);
    wait_idle();
    check_digest();

    // Init clears the chained state
    wb_write(ADDR_CTRL, 32'h1, 4'hF);
    clear_ref_state();
    send_random_block();
    wait_idle();
    check_digest();

    word = $random(seed);
    wb_write(ADDR_MSG, word, 4'b0011);  // Partial write is dropped
    wb_read(ADDR_STATUS, rdata);
    check_value("status", rdata, 32'h4);
    wb_write(ADDR_CTRL, 32'h1, 4'hF);
    clear_ref_state();
    send_random_block();
    wait_idle();
    check_digest();

    if (keccak_ctrl_inst.keccak_ctrl_assertions_inst.fail_count != 0) begin
      $display("Bus or reset assertions failed during the run");
      $display("Test failed");
      $fatal(1, "Assertion failures");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
